//--- mips_core.f
logic/mips_isa_pkg.sv
logic/mips_ctrl_pkg.sv
logic/mips_fetch.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_execute.sv
logic/mips_retire.sv
logic/mips_core.sv
verification/mips_core_chk.sv
verification/mips_core_tb.sv

//--- verification/mips_core_tb.sv
/*
 * Testbench for mips_core: directed programs plus one random program.
 * A reference model predicts the stores, which are compared in order.
 * Instruction memory is combinational; words past the program read as no-op.
 * Programs hold at most 128 words.
 */

`timescale 1ns/1ps

module mips_core_tb;

   localparam mips_isa_pkg::word_t text_start = 32'h00400000;
   localparam int budget  = 200;
   localparam int n_tests = 6;
   localparam int drain   = 6;
   // every budget plus reset cycles, with slack for drain and setup
   localparam int watchdog_ns = n_tests * (budget + 8) * 100 + 10000;

   logic                     clk;
   logic                     rst_b;
   mips_isa_pkg::word_t      inst;
   mips_isa_pkg::word_addr_t inst_addr, mem_addr, fetch_idx;
   mips_isa_pkg::word_t      mem_data_in;
   logic [3:0]               mem_write_en;
   logic                     halted;

   mips_isa_pkg::word_t      prog [128];
   int                       prog_len;
   mips_isa_pkg::word_addr_t exp_addr_q [$];
   mips_isa_pkg::word_t      exp_data_q [$];
   int                       errors, failed_tests, tests_run;

   logic [5:0] r_fns [14] = '{
      mips_isa_pkg::fn_addu, mips_isa_pkg::fn_subu, mips_isa_pkg::fn_and,
      mips_isa_pkg::fn_or, mips_isa_pkg::fn_xor, mips_isa_pkg::fn_nor,
      mips_isa_pkg::fn_slt, mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sll,
      mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra, mips_isa_pkg::fn_sllv,
      mips_isa_pkg::fn_srlv, mips_isa_pkg::fn_srav};
   logic [5:0] i_ops [5] = '{
      mips_isa_pkg::op_addiu, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
      mips_isa_pkg::op_xori, mips_isa_pkg::op_lui};

   mips_core i_dut (.*);

   // instruction memory indexed from the text segment start
   assign fetch_idx = inst_addr - text_start[31:2];
   assign inst      = (fetch_idx < prog_len) ? prog[fetch_idx] : 32'h0;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic mips_isa_pkg::word_t rtype(logic [5:0] fn, int rs, int rt, int rd,
                                                 int sh);
      return {mips_isa_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic mips_isa_pkg::word_t itype(logic [5:0] op, int rs, int rt, int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic int error_total();
      return errors + i_dut.i_chk.violations;
   endfunction

   task automatic emit(mips_isa_pkg::word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   // ori $v0, $0, 10 then syscall
   task automatic finish_program();
      emit(itype(mips_isa_pkg::op_ori, 0, 2, 10));
      emit(rtype(mips_isa_pkg::fn_syscall, 0, 0, 0, 0));
   endtask

   task automatic check_value(string sig, logic [31:0] expected, logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR: %s expected %h actual %h", sig, expected, actual);
         errors++;
      end
   endtask

   // architectural model, runs the program in order and records every store
   task automatic model_program();
      mips_isa_pkg::word_t r [32];
      mips_isa_pkg::word_t w, a, b, simm, zimm, val, addr;
      int                  dst;
      logic                stop, wr;
      for (int i = 0; i < 32; i++) begin
         r[i] = '0;
      end
      exp_addr_q.delete();
      exp_data_q.delete();
      stop = 1'b0;
      for (int pc = 0; pc < prog_len && !stop; pc++) begin
         w    = prog[pc];
         a    = r[w[25:21]];
         b    = r[w[20:16]];
         simm = {{16{w[15]}}, w[15:0]};
         zimm = {16'h0000, w[15:0]};
         dst  = (w[31:26] == mips_isa_pkg::op_special) ? w[15:11] : w[20:16];
         wr   = 1'b1;
         val  = '0;
         case (w[31:26])
            mips_isa_pkg::op_special: begin
               case (w[5:0])
                  mips_isa_pkg::fn_addu: val = a + b;
                  mips_isa_pkg::fn_subu: val = a - b;
                  mips_isa_pkg::fn_and:  val = a & b;
                  mips_isa_pkg::fn_or:   val = a | b;
                  mips_isa_pkg::fn_xor:  val = a ^ b;
                  mips_isa_pkg::fn_nor:  val = ~(a | b);
                  mips_isa_pkg::fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  mips_isa_pkg::fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
                  mips_isa_pkg::fn_sll:  val = b << w[10:6];
                  mips_isa_pkg::fn_srl:  val = b >> w[10:6];
                  mips_isa_pkg::fn_sra:  val = $signed(b) >>> w[10:6];
                  mips_isa_pkg::fn_sllv: val = b << a[4:0];
                  mips_isa_pkg::fn_srlv: val = b >> a[4:0];
                  mips_isa_pkg::fn_srav: val = $signed(b) >>> a[4:0];
                  mips_isa_pkg::fn_syscall: begin
                     wr   = 1'b0;
                     stop = (r[2] == 32'd10);
                  end
                  default: begin
                     wr   = 1'b0;
                     stop = 1'b1;
                  end
               endcase
            end
            mips_isa_pkg::op_addiu: val = a + simm;
            mips_isa_pkg::op_andi:  val = a & zimm;
            mips_isa_pkg::op_ori:   val = a | zimm;
            mips_isa_pkg::op_xori:  val = a ^ zimm;
            mips_isa_pkg::op_lui:   val = {w[15:0], 16'h0000};
            mips_isa_pkg::op_sw: begin
               wr   = 1'b0;
               addr = a + simm;
               exp_addr_q.push_back(addr[31:2]);
               exp_data_q.push_back(b);
            end
            default: begin
               wr   = 1'b0;
               stop = 1'b1;
            end
         endcase
         if (wr && dst != 0) begin
            r[dst] = val;
         end
      end
   endtask

   // reset, run to halt, let the pipeline drain, then report the test
   task automatic run_program(string name);
      int errs_at_start;
      int cyc;
      errs_at_start = error_total();
      model_program();
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (8) @(posedge clk);
      rst_b <= 1'b1;
      @(negedge clk);
      check_value("inst_addr", text_start[31:2], inst_addr);
      check_value("mem_write_en", 32'h0, mem_write_en);
      check_value("halted", 32'h0, halted);
      cyc = 0;
      while (!halted && cyc < budget) begin
         @(negedge clk);
         cyc++;
      end
      assert (halted) else begin
         $display("%s: core did not halt within %0d cycles", name, budget);
         errors++;
      end
      repeat (drain) @(negedge clk);
      @(posedge clk);
      assert (exp_addr_q.size() == 0) else begin
         $display("%s: core halted with %0d expected stores missing", name, exp_addr_q.size());
         errors++;
      end
      tests_run++;
      if (error_total() != errs_at_start) begin
         failed_tests++;
         $display("test %s: FAIL, %0d errors", name, error_total() - errs_at_start);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   // each store is matched against the next predicted one
   always @(negedge clk) begin
      if (rst_b && mem_write_en != 4'h0) begin
         assert (exp_addr_q.size() > 0) else begin
            $display("store to word address %h was not expected", mem_addr);
            errors++;
         end
         if (exp_addr_q.size() > 0) begin
            check_value("mem_addr", exp_addr_q.pop_front(), mem_addr);
            check_value("mem_data_in", exp_data_q.pop_front(), mem_data_in);
         end
      end
   end

   initial begin
      int sel, rs, rt, rd;
      void'($urandom(32'hdb765dbf));
      rst_b        <= 1'b0;
      errors       = 0;
      failed_tests = 0;
      tests_run    = 0;
      prog_len     = 0;

      // one store, then exit
      emit(itype(mips_isa_pkg::op_addiu, 0, 8, 16'h1234));
      emit(itype(mips_isa_pkg::op_sw, 0, 8, 16'h0010));
      finish_program();
      run_program("reset");

      // each op reads the last result and the one before it
      prog_len = 0;
      emit(itype(mips_isa_pkg::op_addiu, 0, 8, 16'h0035));
      emit(itype(mips_isa_pkg::op_addiu, 0, 9, -3));
      emit(rtype(mips_isa_pkg::fn_addu, 9, 8, 10, 0));
      emit(rtype(mips_isa_pkg::fn_subu, 10, 9, 11, 0));
      emit(rtype(mips_isa_pkg::fn_and, 11, 10, 12, 0));
      emit(rtype(mips_isa_pkg::fn_or, 12, 11, 13, 0));
      emit(rtype(mips_isa_pkg::fn_xor, 13, 12, 14, 0));
      emit(rtype(mips_isa_pkg::fn_nor, 14, 13, 15, 0));
      emit(rtype(mips_isa_pkg::fn_slt, 15, 14, 16, 0));
      emit(rtype(mips_isa_pkg::fn_sltu, 16, 15, 17, 0));
      // newest first, so store data also needs forwarding
      for (int k = 17; k >= 10; k--) begin
         emit(itype(mips_isa_pkg::op_sw, 0, k, 16'h0100 + 4 * k));
      end
      finish_program();
      run_program("dependency");

      // negative base, so the upper half shows how andi extends its immediate
      prog_len = 0;
      emit(itype(mips_isa_pkg::op_addiu, 0, 8, 16'h8ff0));
      emit(itype(mips_isa_pkg::op_addiu, 8, 9, -256));
      emit(itype(mips_isa_pkg::op_andi, 9, 10, 16'h8f0f));
      emit(itype(mips_isa_pkg::op_ori, 0, 11, 16'h8001));
      emit(itype(mips_isa_pkg::op_xori, 9, 12, 16'hf0f0));
      emit(itype(mips_isa_pkg::op_lui, 0, 13, 16'h8765));
      emit(rtype(mips_isa_pkg::fn_sll, 0, 13, 14, 4));
      emit(rtype(mips_isa_pkg::fn_srl, 0, 13, 15, 7));
      emit(rtype(mips_isa_pkg::fn_sra, 0, 13, 16, 7));
      // 35 shifts by its low five bits, 3
      emit(itype(mips_isa_pkg::op_addiu, 0, 17, 35));
      emit(rtype(mips_isa_pkg::fn_sllv, 17, 13, 18, 0));
      emit(rtype(mips_isa_pkg::fn_srlv, 17, 13, 19, 0));
      emit(rtype(mips_isa_pkg::fn_srav, 17, 13, 20, 0));
      emit(itype(mips_isa_pkg::op_addiu, 0, 21, 16'h0200));
      for (int k = 8; k <= 20; k++) begin
         emit(itype(mips_isa_pkg::op_sw, 21, k, -4 * (k - 7)));
      end
      finish_program();
      run_program("immediates");

      // $v0 = 5 makes the first syscall a no-op
      prog_len = 0;
      emit(itype(mips_isa_pkg::op_addiu, 0, 2, 5));
      emit(rtype(mips_isa_pkg::fn_syscall, 0, 0, 0, 0));
      emit(itype(mips_isa_pkg::op_addiu, 0, 8, 16'h0077));
      emit(itype(mips_isa_pkg::op_sw, 0, 8, 16'h0040));
      finish_program();
      emit(itype(mips_isa_pkg::op_sw, 0, 8, 16'h0044));
      run_program("syscall");

      // opcode 0x3f is undefined
      prog_len = 0;
      emit(itype(mips_isa_pkg::op_addiu, 0, 8, 16'h0055));
      emit(itype(mips_isa_pkg::op_sw, 0, 8, 16'h0050));
      emit(32'hfc000000);
      emit(itype(mips_isa_pkg::op_sw, 0, 8, 16'h0054));
      finish_program();
      run_program("reserved");

      // registers 0..7 only, so $0 is hit as a destination now and then
      prog_len = 0;
      for (int k = 1; k <= 7; k++) begin
         emit(itype(mips_isa_pkg::op_addiu, 0, k, $urandom));
      end
      for (int k = 0; k < 24; k++) begin
         sel = $urandom_range(18, 0);
         rs  = $urandom_range(7, 0);
         rt  = $urandom_range(7, 0);
         rd  = $urandom_range(7, 0);
         if (sel < 14) begin
            emit(rtype(r_fns[sel], rs, rt, rd, $urandom_range(31, 0)));
         end else begin
            emit(itype(i_ops[sel - 14], rs, rd, $urandom));
         end
         emit(itype(mips_isa_pkg::op_sw, 0, rd, 16'h0400 + 4 * k));
      end
      finish_program();
      run_program("random");

      $display("%0d tests run, %0d failed, %0d errors, %0d checker failures",
               tests_run, failed_tests, errors, i_dut.i_chk.violations);
      if (failed_tests == 0 && error_total() == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired before all tests finished");
      $display("Test failures found");
      $finish;
   end

endmodule

//--- verification/mips_core_chk.sv
/*
 * Port properties of mips_core, bound into every instance.
 * All properties are idle while rst_b is low.
 * violations counts failed properties for the testbench summary.
 */

`timescale 1ns/1ps

module mips_core_chk (
   input logic                     clk,
   input logic                     rst_b,
   input mips_isa_pkg::word_addr_t inst_addr,
   input logic [3:0]               mem_write_en,
   input logic                     halted
);

   int violations = 0;

   // stores always write the whole word
   a_full_word: assert property (
      @(posedge clk) disable iff (!rst_b)
      (mem_write_en == 4'h0) || (mem_write_en == 4'hf)
   ) else begin
      $error("mem_write_en is %h, not a whole-word mask", mem_write_en);
      violations++;
   end

   // no stalls, the pc steps every cycle until halt
   // sampled rst_b skips the release edge, where the pc still holds its reset value
   a_pc_step: assert property (
      @(posedge clk) disable iff (!rst_b)
      rst_b && !halted |=> inst_addr == $past(inst_addr) + 30'd1
   ) else begin
      $error("inst_addr did not advance by one while running");
      violations++;
   end

   // halt is sticky and freezes fetch
   a_halt_hold: assert property (
      @(posedge clk) disable iff (!rst_b)
      halted |=> halted && $stable(inst_addr)
   ) else begin
      $error("halted dropped or inst_addr moved after halt");
      violations++;
   end

   a_no_store_halted: assert property (
      @(posedge clk) disable iff (!rst_b)
      halted |-> mem_write_en == 4'h0
   ) else begin
      $error("store issued while halted");
      violations++;
   end

endmodule

bind mips_core mips_core_chk i_chk (.*);

//--- logic/mips_core.sv
/*
 * Four-stage in-order MIPS integer core: fetch, decode, execute, retire.
 * No loads, branches or HI/LO. Stores are full words only.
 * inst must hold the word at inst_addr within the same cycle.
 * Memory accepts every store, there is no back-pressure.
 */

`timescale 1ns/1ps

module mips_core #(
   parameter mips_isa_pkg::word_t text_start = 32'h00400000
) (
   input  logic                     clk,
   input  logic                     rst_b,
   input  mips_isa_pkg::word_t      inst,
   output mips_isa_pkg::word_addr_t inst_addr,
   output mips_isa_pkg::word_addr_t mem_addr,
   output mips_isa_pkg::word_t      mem_data_in,
   output logic [3:0]               mem_write_en,
   output logic                     halted
);

   // fetch to decode
   mips_isa_pkg::word_t     inst_d;
   // register file read ports
   mips_isa_pkg::reg_idx_t  rs_idx, rt_idx;
   mips_isa_pkg::word_t     rs_data, rt_data;
   // execute stage registers
   mips_ctrl_pkg::alu_op_e  ex_op;
   mips_ctrl_pkg::opb_sel_e ex_opb_sel;
   mips_isa_pkg::reg_idx_t  ex_rs_idx, ex_rt_idx, ex_dest;
   mips_isa_pkg::word_t     ex_rs_val, ex_rt_val, ex_imm;
   mips_isa_pkg::shamt_t    ex_shamt;
   logic                    ex_we, ex_store, ex_sys, ex_ri;
   // retire stage registers
   mips_isa_pkg::word_t     wb_result, wb_store_val;
   mips_isa_pkg::reg_idx_t  wb_dest;
   logic                    wb_we, wb_store, wb_sys, wb_ri;
   // register write, also the forwarding source
   logic                    wr_en;
   mips_isa_pkg::reg_idx_t  wr_idx;
   mips_isa_pkg::word_t     wr_data;

   mips_fetch #(.text_start(text_start)) i_fetch (.*);

   mips_decode i_decode (.*);

   mips_regfile i_regfile (.*);

   mips_execute i_execute (.*);

   mips_retire i_retire (.*);

endmodule

//--- logic/mips_retire.sv
/*
 * Retire stage: register write, store port and the halt flag.
 * Once halted, nothing behind the halting instruction takes effect.
 * halted is sticky until reset.
 */

`timescale 1ns/1ps

module mips_retire (
   input  logic                     clk,
   input  logic                     rst_b,
   input  mips_isa_pkg::word_t      wb_result,
   input  mips_isa_pkg::word_t      wb_store_val,
   input  mips_isa_pkg::reg_idx_t   wb_dest,
   input  logic                     wb_we,
   input  logic                     wb_store,
   input  logic                     wb_sys,
   input  logic                     wb_ri,
   output logic                     wr_en,
   output mips_isa_pkg::reg_idx_t   wr_idx,
   output mips_isa_pkg::word_t      wr_data,
   output mips_isa_pkg::word_addr_t mem_addr,
   output mips_isa_pkg::word_t      mem_data_in,
   output logic [3:0]               mem_write_en,
   output logic                     halted
);

   logic halt_set;

   assign wr_en   = wb_we && !halted;
   assign wr_idx  = wb_dest;
   assign wr_data = wb_result;

   // full-word stores only, so all byte lanes go together
   assign mem_addr     = wb_result[31:2];
   assign mem_data_in  = wb_store_val;
   assign mem_write_en = {4{wb_store && !halted}};

   // syscall exits only when $v0 holds the exit code
   assign halt_set = !halted &&
                     (wb_ri || (wb_sys && (wb_store_val == mips_isa_pkg::syscall_exit)));

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (halt_set) begin
         halted <= 1'b1;
      end
   end

endmodule

//--- logic/mips_execute.sv
/*
 * Operand forwarding from retire, the ALU and the retire-stage registers.
 * Only one forwarding source exists since the pipeline has no
 * stage between execute and retire.
 */

`timescale 1ns/1ps

module mips_execute (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_ctrl_pkg::alu_op_e  ex_op,
   input  mips_ctrl_pkg::opb_sel_e ex_opb_sel,
   input  mips_isa_pkg::reg_idx_t  ex_rs_idx,
   input  mips_isa_pkg::reg_idx_t  ex_rt_idx,
   input  mips_isa_pkg::word_t     ex_rs_val,
   input  mips_isa_pkg::word_t     ex_rt_val,
   input  mips_isa_pkg::word_t     ex_imm,
   input  mips_isa_pkg::shamt_t    ex_shamt,
   input  mips_isa_pkg::reg_idx_t  ex_dest,
   input  logic                    ex_we,
   input  logic                    ex_store,
   input  logic                    ex_sys,
   input  logic                    ex_ri,
   input  logic                    wr_en,
   input  mips_isa_pkg::reg_idx_t  wr_idx,
   input  mips_isa_pkg::word_t     wr_data,
   output mips_isa_pkg::word_t     wb_result,
   output mips_isa_pkg::word_t     wb_store_val,
   output mips_isa_pkg::reg_idx_t  wb_dest,
   output logic                    wb_we,
   output logic                    wb_store,
   output logic                    wb_sys,
   output logic                    wb_ri
);

   mips_isa_pkg::word_t rs_fwd, rt_fwd, opb, alu_out;
   logic                rs_hit, rt_hit;

   // the retiring instruction's result replaces a stale read
   assign rs_hit = wr_en && (wr_idx == ex_rs_idx) && (ex_rs_idx != mips_isa_pkg::reg_zero);
   assign rt_hit = wr_en && (wr_idx == ex_rt_idx) && (ex_rt_idx != mips_isa_pkg::reg_zero);
   assign rs_fwd = rs_hit ? wr_data : ex_rs_val;
   assign rt_fwd = rt_hit ? wr_data : ex_rt_val;
   assign opb    = (ex_opb_sel == mips_ctrl_pkg::opb_imm) ? ex_imm : rt_fwd;

   always_comb begin
      case (ex_op)
         mips_ctrl_pkg::alu_add:  alu_out = rs_fwd + opb;
         mips_ctrl_pkg::alu_sub:  alu_out = rs_fwd - opb;
         mips_ctrl_pkg::alu_and:  alu_out = rs_fwd & opb;
         mips_ctrl_pkg::alu_or:   alu_out = rs_fwd | opb;
         mips_ctrl_pkg::alu_xor:  alu_out = rs_fwd ^ opb;
         mips_ctrl_pkg::alu_nor:  alu_out = ~(rs_fwd | opb);
         mips_ctrl_pkg::alu_slt:  alu_out = {31'b0, $signed(rs_fwd) < $signed(opb)};
         mips_ctrl_pkg::alu_sltu: alu_out = {31'b0, rs_fwd < opb};
         // fixed shifts take the amount from the instruction
         mips_ctrl_pkg::alu_sll:  alu_out = opb << ex_shamt;
         mips_ctrl_pkg::alu_srl:  alu_out = opb >> ex_shamt;
         mips_ctrl_pkg::alu_sra:  alu_out = $signed(opb) >>> ex_shamt;
         // variable shifts use only the low five bits of rs
         mips_ctrl_pkg::alu_sllv: alu_out = opb << rs_fwd[4:0];
         mips_ctrl_pkg::alu_srlv: alu_out = opb >> rs_fwd[4:0];
         mips_ctrl_pkg::alu_srav: alu_out = $signed(opb) >>> rs_fwd[4:0];
         mips_ctrl_pkg::alu_lui:  alu_out = {opb[15:0], 16'h0000};
         default:                 alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_we    <= 1'b0;
         wb_store <= 1'b0;
         wb_sys   <= 1'b0;
         wb_ri    <= 1'b0;
      end else begin
         wb_we    <= ex_we;
         wb_store <= ex_store;
         wb_sys   <= ex_sys;
         wb_ri    <= ex_ri;
      end
   end

   // store data and the syscall's $v0 both travel as the rt value
   always_ff @(posedge clk) begin
      wb_result    <= alu_out;
      wb_store_val <= rt_fwd;
      wb_dest      <= ex_dest;
   end

endmodule

//--- logic/mips_regfile.sv
/*
 * 32-entry register file, two read ports and one write port.
 * A read of the register written in the same cycle returns the new value.
 */

`timescale 1ns/1ps

module mips_regfile (
   input  logic                   clk,
   input  logic                   rst_b,
   input  mips_isa_pkg::reg_idx_t rs_idx,
   input  mips_isa_pkg::reg_idx_t rt_idx,
   input  logic                   wr_en,
   input  mips_isa_pkg::reg_idx_t wr_idx,
   input  mips_isa_pkg::word_t    wr_data,
   output mips_isa_pkg::word_t    rs_data,
   output mips_isa_pkg::word_t    rt_data
);

   mips_isa_pkg::word_t regs [32];

   // $0 is never written, and the read mux forces it to zero anyway
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_idx != mips_isa_pkg::reg_zero)) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // write-through read, shared by both ports
   function automatic mips_isa_pkg::word_t read_port(mips_isa_pkg::reg_idx_t idx);
      if (idx == mips_isa_pkg::reg_zero) begin
         return '0;
      end else if (wr_en && (wr_idx == idx)) begin
         return wr_data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs_data = read_port(rs_idx);
   end

   always_comb begin
      rt_data = read_port(rt_idx);
   end

endmodule

//--- logic/mips_decode.sv
/*
 * Field extraction, control decode and execute-stage registers.
 * Anything outside the supported subset is flagged as reserved.
 * Writes to $0 are dropped here by clearing the write enable.
 */

`timescale 1ns/1ps

module mips_decode (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_isa_pkg::word_t     inst_d,
   input  mips_isa_pkg::word_t     rs_data,
   input  mips_isa_pkg::word_t     rt_data,
   output mips_isa_pkg::reg_idx_t  rs_idx,
   output mips_isa_pkg::reg_idx_t  rt_idx,
   output mips_ctrl_pkg::alu_op_e  ex_op,
   output mips_ctrl_pkg::opb_sel_e ex_opb_sel,
   output mips_isa_pkg::reg_idx_t  ex_rs_idx,
   output mips_isa_pkg::reg_idx_t  ex_rt_idx,
   output mips_isa_pkg::word_t     ex_rs_val,
   output mips_isa_pkg::word_t     ex_rt_val,
   output mips_isa_pkg::word_t     ex_imm,
   output mips_isa_pkg::shamt_t    ex_shamt,
   output mips_isa_pkg::reg_idx_t  ex_dest,
   output logic                    ex_we,
   output logic                    ex_store,
   output logic                    ex_sys,
   output logic                    ex_ri
);

   logic [5:0]              opcode, funct;
   mips_isa_pkg::reg_idx_t  rd_field, dest;
   mips_isa_pkg::imm16_t    imm;
   mips_isa_pkg::word_t     imm_ext;
   mips_ctrl_pkg::alu_op_e  op;
   mips_ctrl_pkg::opb_sel_e opb_sel;
   logic                    is_rtype, sign_ext, we, store, sys, ri;

   assign opcode   = inst_d[31:26];
   assign funct    = inst_d[5:0];
   assign rd_field = inst_d[15:11];
   assign imm      = inst_d[15:0];

   always_comb begin
      op       = mips_ctrl_pkg::alu_add;
      opb_sel  = mips_ctrl_pkg::opb_imm;
      is_rtype = 1'b0;
      sign_ext = 1'b0;
      we       = 1'b1;
      store    = 1'b0;
      sys      = 1'b0;
      ri       = 1'b0;
      case (opcode)
         mips_isa_pkg::op_special: begin
            is_rtype = 1'b1;
            opb_sel  = mips_ctrl_pkg::opb_rt;
            case (funct)
               mips_isa_pkg::fn_addu: op = mips_ctrl_pkg::alu_add;
               mips_isa_pkg::fn_subu: op = mips_ctrl_pkg::alu_sub;
               mips_isa_pkg::fn_and:  op = mips_ctrl_pkg::alu_and;
               mips_isa_pkg::fn_or:   op = mips_ctrl_pkg::alu_or;
               mips_isa_pkg::fn_xor:  op = mips_ctrl_pkg::alu_xor;
               mips_isa_pkg::fn_nor:  op = mips_ctrl_pkg::alu_nor;
               mips_isa_pkg::fn_slt:  op = mips_ctrl_pkg::alu_slt;
               mips_isa_pkg::fn_sltu: op = mips_ctrl_pkg::alu_sltu;
               mips_isa_pkg::fn_sll:  op = mips_ctrl_pkg::alu_sll;
               mips_isa_pkg::fn_srl:  op = mips_ctrl_pkg::alu_srl;
               mips_isa_pkg::fn_sra:  op = mips_ctrl_pkg::alu_sra;
               mips_isa_pkg::fn_sllv: op = mips_ctrl_pkg::alu_sllv;
               mips_isa_pkg::fn_srlv: op = mips_ctrl_pkg::alu_srlv;
               mips_isa_pkg::fn_srav: op = mips_ctrl_pkg::alu_srav;
               mips_isa_pkg::fn_syscall: begin
                  we  = 1'b0;
                  sys = 1'b1;
               end
               default: begin
                  we = 1'b0;
                  ri = 1'b1;
               end
            endcase
         end
         mips_isa_pkg::op_addiu: sign_ext = 1'b1;
         mips_isa_pkg::op_andi:  op = mips_ctrl_pkg::alu_and;
         mips_isa_pkg::op_ori:   op = mips_ctrl_pkg::alu_or;
         mips_isa_pkg::op_xori:  op = mips_ctrl_pkg::alu_xor;
         mips_isa_pkg::op_lui:   op = mips_ctrl_pkg::alu_lui;
         mips_isa_pkg::op_sw: begin
            // address is rs plus the signed offset
            sign_ext = 1'b1;
            we       = 1'b0;
            store    = 1'b1;
         end
         default: begin
            we = 1'b0;
            ri = 1'b1;
         end
      endcase
   end

   assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
   assign dest    = is_rtype ? rd_field : inst_d[20:16];
   assign rs_idx  = inst_d[25:21];
   // syscall reads $v0 through the rt port
   assign rt_idx  = sys ? mips_isa_pkg::reg_v0 : inst_d[20:16];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_we    <= 1'b0;
         ex_store <= 1'b0;
         ex_sys   <= 1'b0;
         ex_ri    <= 1'b0;
      end else begin
         ex_we    <= we && (dest != mips_isa_pkg::reg_zero);
         ex_store <= store;
         ex_sys   <= sys;
         ex_ri    <= ri;
      end
   end

   always_ff @(posedge clk) begin
      ex_op      <= op;
      ex_opb_sel <= opb_sel;
      ex_rs_idx  <= rs_idx;
      ex_rt_idx  <= rt_idx;
      ex_rs_val  <= rs_data;
      ex_rt_val  <= rt_data;
      ex_imm     <= imm_ext;
      ex_shamt   <= inst_d[10:6];
      ex_dest    <= dest;
   end

endmodule

//--- logic/mips_fetch.sv
/*
 * Program counter and decode-stage instruction register.
 * No stalls: both advance every cycle until halted.
 * text_start must be word aligned.
 */

`timescale 1ns/1ps

module mips_fetch #(
   parameter mips_isa_pkg::word_t text_start = 32'h00400000
) (
   input  logic                     clk,
   input  logic                     rst_b,
   input  mips_isa_pkg::word_t      inst,
   input  logic                     halted,
   output mips_isa_pkg::word_addr_t inst_addr,
   output mips_isa_pkg::word_t      inst_d
);

   // pc is kept as a word address, the byte offset is always zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_addr <= text_start[31:2];
         // all-zero word decodes as sll $0, a no-op
         inst_d    <= '0;
      end else if (!halted) begin
         inst_addr <= inst_addr + 30'd1;
         inst_d    <= inst;
      end
   end

endmodule

//--- logic/mips_ctrl_pkg.sv
/*
 * Internal control encodings passed between pipeline stages.
 * The values are private to the core and carry no ISA meaning.
 */

package mips_ctrl_pkg;

   // alu function chosen in decode
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_slt,
      alu_sltu,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_sllv,
      alu_srlv,
      alu_srav,
      alu_lui
   } alu_op_e;

   // source of the second alu operand
   typedef enum logic {
      opb_rt,
      opb_imm
   } opb_sel_e;

endpackage

//--- logic/mips_isa_pkg.sv
/*
 * MIPS32 instruction-set facts used by the core.
 * Covers only the integer subset this core decodes.
 * Field positions follow the standard R and I formats.
 */

package mips_isa_pkg;

   typedef logic [31:0] word_t;
   // byte address with the two low bits dropped
   typedef logic [29:0] word_addr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [15:0] imm16_t;
   typedef logic [4:0]  shamt_t;

   // primary opcodes, bits 31:26
   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_addiu   = 6'h09;
   localparam logic [5:0] op_andi    = 6'h0c;
   localparam logic [5:0] op_ori     = 6'h0d;
   localparam logic [5:0] op_xori    = 6'h0e;
   localparam logic [5:0] op_lui     = 6'h0f;
   localparam logic [5:0] op_sw      = 6'h2b;

   // funct field of op_special, bits 5:0
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_sllv    = 6'h04;
   localparam logic [5:0] fn_srlv    = 6'h06;
   localparam logic [5:0] fn_srav    = 6'h07;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;
   localparam logic [5:0] fn_nor     = 6'h27;
   localparam logic [5:0] fn_slt     = 6'h2a;
   localparam logic [5:0] fn_sltu    = 6'h2b;

   // register numbers with a fixed role
   localparam reg_idx_t reg_zero = 5'd0;
   localparam reg_idx_t reg_v0   = 5'd2;

   // $v0 code that makes syscall stop the core
   localparam word_t syscall_exit = 32'd10;

endpackage
